// File: design/avr_io_pkg.sv
`default_nettype none

package avr_io_pkg;

    // Default parameter values
    localparam int DMEM_WIDTH_DEF = 10;   // Data address bits, MSB picks RAM or MMIO
    localparam int DIV_RESET_DEF  = 3;    // UART divisor out of reset

    // One request on the data bus
    typedef struct packed {
        logic                      re;     // Single-cycle read strobe
        logic                      we;     // Single-cycle write strobe
        logic [DMEM_WIDTH_DEF-1:0] addr;   // Byte address
        logic [7:0]                wdata;  // Write data
    } dbus_req_t;

    // MMIO register offsets, low 3 address bits
    typedef enum logic [2:0] {
        REG_LED    = 3'd0,   // LED output latch
        REG_SW     = 3'd1,   // Switch inputs, read only
        REG_DIV    = 3'd2,   // UART bit divisor
        REG_TXDATA = 3'd3,   // Write sends a byte, read gives status
        REG_IRQCLR = 3'd4    // Write 1 to done bit to clear it
    } mmio_reg_e;

    // Transmitter states
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } uart_state_e;

    // Bits in the status byte
    localparam int STAT_BUSY_BIT = 0;
    localparam int STAT_DONE_BIT = 1;

endpackage : avr_io_pkg

`default_nettype wire

// File: design/dbus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module dbus_decoder
    import avr_io_pkg::*;
#(
    parameter int dmem_width = DMEM_WIDTH_DEF
) (
    input  wire       clk,
    input  wire       arst_n,
    input  wire       dbus_req_t req,
    output logic      ram_re,
    output logic      ram_we,
    output logic      mmio_re,
    output logic      mmio_we,
    input  wire [7:0] ram_rdata,
    input  wire [7:0] mmio_rdata,
    output logic [7:0] rdata
);

    logic io_sel;      // Address MSB set means MMIO
    logic rd_mmio_q;   // Last read went to MMIO

    assign io_sel = req.addr[dmem_width-1];

    // Steer strobes by the MSB
    assign ram_re  = req.re & ~io_sel;
    assign ram_we  = req.we & ~io_sel;
    assign mmio_re = req.re &  io_sel;
    assign mmio_we = req.we &  io_sel;

    // Remember where the last read went, held until the next read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_mmio_q <= 1'b0;                  // Point at RAM out of reset
        end else if (mmio_re) begin
            rd_mmio_q <= 1'b1;
        end else if (ram_re) begin
            rd_mmio_q <= 1'b0;
        end
    end

    // Both sources hold their read data, so only the flag picks
    assign rdata = rd_mmio_q ? mmio_rdata : ram_rdata;

    // Master never issues read and write together
    a_no_rw_overlap : assert property (
        @(posedge clk) disable iff (!arst_n)
        !(req.re && req.we)
    ) else $error("dbus_decoder: read and write strobes set together");

endmodule : dbus_decoder

`default_nettype wire

// File: design/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram
    import avr_io_pkg::*;
#(
    parameter int dmem_width = DMEM_WIDTH_DEF
) (
    input  wire       clk,
    input  wire       re,
    input  wire       we,
    input  wire       dbus_req_t req,
    output logic [7:0] rdata
);

    localparam int DEPTH = 2 ** (dmem_width - 1);   // MSB is the RAM/MMIO select

    logic [7:0]            mem [DEPTH];
    logic [dmem_width-2:0] idx;

    assign idx = req.addr[dmem_width-2:0];   // Drop the select bit

    // Write lands at the strobe edge
    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= req.wdata;
        end
    end

    // Registered read port
    // Holds its value between reads so the decoder can keep steering it
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[idx];   // Valid the cycle after the strobe
        end
    end

endmodule : data_ram

`default_nettype wire

// File: design/io_regs.sv
`timescale 1ns/1ps
`default_nettype none

module io_regs
    import avr_io_pkg::*;
#(
    parameter logic [7:0] div_reset = 8'(DIV_RESET_DEF)
) (
    input  wire        clk,
    input  wire        arst_n,
    input  wire        re,
    input  wire        we,
    input  wire        dbus_req_t req,
    input  wire  [7:0] sw,
    input  wire        tx_busy,
    input  wire        tx_done,
    output logic [7:0] rdata,
    output logic [7:0] led,
    output logic [7:0] divisor,
    output logic       tx_start,
    output logic [7:0] tx_byte,
    output logic       done_irq
);

    mmio_reg_e  offset;
    logic [7:0] rd_mux;
    logic       done_q;   // Sticky transmit-done flag

    assign offset = mmio_reg_e'(req.addr[2:0]);   // Upper MMIO bits alias

    // Kick the transmitter only when it is free, busy writes are dropped
    assign tx_start = we && (offset == REG_TXDATA) && !tx_busy;
    assign tx_byte  = req.wdata;
    assign done_irq = done_q;                     // Interrupt line 0

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            led     <= '0;
            divisor <= div_reset;
            done_q  <= 1'b0;
        end else begin
            if (we && offset == REG_LED)
                led <= req.wdata;
            if (we && offset == REG_DIV)
                divisor <= req.wdata;
            // New completion beats a clear in the same cycle
            if (tx_done)
                done_q <= 1'b1;
            else if (we && offset == REG_IRQCLR && req.wdata[STAT_DONE_BIT])
                done_q <= 1'b0;
        end
    end

    // Read mux
    always_comb begin
        rd_mux = '0;
        case (offset)
            REG_LED:    rd_mux = led;
            REG_SW:     rd_mux = sw;
            REG_DIV:    rd_mux = divisor;
            REG_TXDATA: begin
                rd_mux[STAT_BUSY_BIT] = tx_busy;   // Status byte on read
                rd_mux[STAT_DONE_BIT] = done_q;
            end
            default:    rd_mux = '0;               // Write-only or unused offsets
        endcase
    end

    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= rd_mux;
        end
    end

    // Accepted start is never during a frame and the UART picks it up next cycle
    a_start_when_idle : assert property (
        @(posedge clk) disable iff (!arst_n)
        tx_start |-> !tx_busy ##1 tx_busy
    ) else $error("io_regs: tx_start not taken by an idle transmitter");

endmodule : io_regs

`default_nettype wire

// File: design/baud_timer.sv
`timescale 1ns/1ps
`default_nettype none

module baud_timer (
    input  wire       clk,
    input  wire       arst_n,
    input  wire       tick_en,
    input  wire [7:0] divisor,
    output logic      bit_tick
);

    logic [7:0] cnt_q;

    // Fires on the last cycle of each bit, divisor+1 cycles apart
    assign bit_tick = tick_en && (cnt_q == 8'd0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt_q <= '0;
        end else if (!tick_en || bit_tick) begin
            cnt_q <= divisor;              // Idle or end of bit, start over
        end else begin
            cnt_q <= cnt_q - 8'd1;
        end
    end

endmodule : baud_timer

`default_nettype wire

// File: design/uart_tx_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_fsm
    import avr_io_pkg::*;
(
    input  wire       clk,
    input  wire       arst_n,
    input  wire       tx_start,
    input  wire [7:0] tx_byte,
    input  wire       bit_tick,
    output logic      tick_en,
    output logic      txd,
    output logic      tx_busy,
    output logic      tx_done
);

    uart_state_e state;
    logic [7:0]  shift_q;   // Data bits, LSB goes out first
    logic [2:0]  bit_idx;   // Data bit counter

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            bit_idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (tx_start)
                        state <= START;
                end
                START: begin
                    if (bit_tick) begin
                        state   <= DATA;
                        bit_idx <= '0;
                    end
                end
                DATA: begin
                    if (bit_tick) begin
                        if (bit_idx == 3'd7)
                            state <= STOP;      // Eighth bit done
                        bit_idx <= bit_idx + 3'd1;
                    end
                end
                STOP: begin
                    if (bit_tick)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Byte is loaded on start and shifted right after each data bit
    always_ff @(posedge clk) begin
        if (state == IDLE && tx_start)
            shift_q <= tx_byte;
        else if (state == DATA && bit_tick)
            shift_q <= {1'b0, shift_q[7:1]};
    end

    // Line level from state
    always_comb begin
        case (state)
            START:   txd = 1'b0;          // Start bit
            DATA:    txd = shift_q[0];
            default: txd = 1'b1;          // Idle and stop are mark
        endcase
    end

    assign tick_en = (state != IDLE);           // Timer runs only in a frame
    assign tx_busy = (state != IDLE);
    assign tx_done = (state == STOP) && bit_tick;   // End of stop bit

    // Timer is held in reload while idle
    a_no_tick_in_idle : assert property (
        @(posedge clk) disable iff (!arst_n)
        (state == IDLE) |-> !bit_tick
    ) else $error("uart_tx_fsm: bit_tick while idle");

endmodule : uart_tx_fsm

`default_nettype wire

// File: design/irq_priority_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module irq_priority_encoder (
    input  wire  [3:0] irq_lines,
    output logic       iflag,
    output logic [1:0] ivect
);

    // Line 0 has highest priority
    always_comb begin
        if (irq_lines[0])
            ivect = 2'd0;
        else if (irq_lines[1])
            ivect = 2'd1;
        else if (irq_lines[2])
            ivect = 2'd2;
        else if (irq_lines[3])
            ivect = 2'd3;
        else
            ivect = 2'd0;   // Nothing pending, iflag tells it apart
    end

    assign iflag = |irq_lines;

endmodule : irq_priority_encoder

`default_nettype wire

// File: design/avr_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module avr_io_top
    import avr_io_pkg::*;
#(
    parameter int         dmem_width = DMEM_WIDTH_DEF,
    parameter logic [7:0] div_reset  = 8'(DIV_RESET_DEF)
) (
    input  wire        clk,
    input  wire        arst_n,
    input  wire        dbus_req_t req,
    input  wire  [7:0] sw,
    input  wire  [2:0] ext_irq,
    output logic [7:0] rdata,
    output logic [7:0] led,
    output logic       txd,
    output logic       iflag,
    output logic [1:0] ivect
);

    logic       ram_re;
    logic       ram_we;
    logic       mmio_re;
    logic       mmio_we;
    logic [7:0] ram_rdata;
    logic [7:0] mmio_rdata;
    logic [7:0] divisor;
    logic       tx_start;
    logic [7:0] tx_byte;
    logic       tx_busy;
    logic       tx_done;
    logic       done_irq;
    logic       tick_en;
    logic       bit_tick;

    dbus_decoder #(.dmem_width(dmem_width)) i_dbus_decoder (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .ram_re     (ram_re),
        .ram_we     (ram_we),
        .mmio_re    (mmio_re),
        .mmio_we    (mmio_we),
        .ram_rdata  (ram_rdata),
        .mmio_rdata (mmio_rdata),
        .rdata      (rdata)
    );

    data_ram #(.dmem_width(dmem_width)) i_data_ram (
        .clk   (clk),
        .re    (ram_re),
        .we    (ram_we),
        .req   (req),
        .rdata (ram_rdata)
    );

    io_regs #(.div_reset(div_reset)) i_io_regs (
        .clk      (clk),
        .arst_n   (arst_n),
        .re       (mmio_re),
        .we       (mmio_we),
        .req      (req),
        .sw       (sw),
        .tx_busy  (tx_busy),
        .tx_done  (tx_done),
        .rdata    (mmio_rdata),
        .led      (led),
        .divisor  (divisor),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .done_irq (done_irq)
    );

    baud_timer i_baud_timer (
        .clk      (clk),
        .arst_n   (arst_n),
        .tick_en  (tick_en),
        .divisor  (divisor),
        .bit_tick (bit_tick)
    );

    uart_tx_fsm i_uart_tx_fsm (
        .clk      (clk),
        .arst_n   (arst_n),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .bit_tick (bit_tick),
        .tick_en  (tick_en),
        .txd      (txd),
        .tx_busy  (tx_busy),
        .tx_done  (tx_done)
    );

    // UART done on line 0, external lines above it
    irq_priority_encoder i_irq_priority_encoder (
        .irq_lines ({ext_irq, done_irq}),
        .iflag     (iflag),
        .ivect     (ivect)
    );

endmodule : avr_io_top

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns    = 10,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;   // Free-running clock
    end

    // Reset held low for the first few edges, released just after an edge
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule : tb_clock_gen

`default_nettype wire

// File: verification/tb_avr_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_avr_io_top
    import avr_io_pkg::*;
();

    localparam int DMEM_WIDTH = DMEM_WIDTH_DEF;
    localparam int DIV_RESET  = DIV_RESET_DEF;
    localparam int MAX_OPS    = 128;

    // Operation codes in the data file
    localparam logic [3:0] OP_END   = 4'h0;
    localparam logic [3:0] OP_WRITE = 4'h1;
    localparam logic [3:0] OP_READ  = 4'h2;
    localparam logic [3:0] OP_SW    = 4'h3;
    localparam logic [3:0] OP_IRQ   = 4'h4;   // Expect byte holds iflag at bit 4 and ivect below
    localparam logic [3:0] OP_UART  = 4'h5;
    localparam logic [3:0] OP_QUIET = 4'h6;   // Wdata is the number of cycles
    localparam logic [3:0] OP_LED   = 4'h8;

    logic        clk;
    logic        arst_n;
    dbus_req_t   req;
    logic [7:0]  sw;
    logic [2:0]  ext_irq;
    logic [7:0]  rdata;
    logic [7:0]  led;
    logic        txd;
    logic        iflag;
    logic [1:0]  ivect;

    logic [31:0] ops [MAX_OPS];   // {op, addr, wdata, expect}
    int          num_ops;
    int          bit_div;         // Divisor as last written by the master
    logic [7:0]  rx_queue [$];    // Bytes seen on txd
    logic        in_frame;
    logic        mon_prev;
    logic [7:0]  mon_shift;
    int          mon_bt;

    tb_clock_gen #(.period_ns(10), .reset_cycles(4)) i_tb_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    avr_io_top #(
        .dmem_width (DMEM_WIDTH),
        .div_reset  (8'(DIV_RESET))
    ) i_avr_io_top (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (req),
        .sw      (sw),
        .ext_irq (ext_irq),
        .rdata   (rdata),
        .led     (led),
        .txd     (txd),
        .iflag   (iflag),
        .ivect   (ivect)
    );

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] expv);
        if (got !== expv) begin
            $display("CHECK FAILED at %0d ns: %s expected 8'h%02h got 8'h%02h",
                     $time, name, expv, got);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expv);
        if (got !== expv) begin
            $display("CHECK FAILED at %0d ns: %s expected %b got %b", $time, name, expv, got);
            abort_run();
        end
    endtask

    task automatic check_irq(input logic got_flag, input logic [1:0] got_vect,
                             input logic exp_flag, input logic [1:0] exp_vect);
        if (got_flag !== exp_flag || got_vect !== exp_vect) begin
            $display("CHECK FAILED at %0d ns: iflag/ivect expected %b/%0d got %b/%0d",
                     $time, exp_flag, exp_vect, got_flag, got_vect);
            abort_run();
        end
    endtask

    // Every task starts and ends 1 ns after a rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_gap();
        repeat ($urandom_range(3, 0)) next_cycle();
    endtask

    task automatic bus_write(input logic [DMEM_WIDTH-1:0] addr, input logic [7:0] wdata);
        req.re    = 1'b0;
        req.we    = 1'b1;
        req.addr  = addr;
        req.wdata = wdata;
        next_cycle();                       // Strobe sampled here
        req = '0;
        if (addr[DMEM_WIDTH-1] && mmio_reg_e'(addr[2:0]) == REG_DIV)
            bit_div = wdata;                // Track bit time for the monitor
    endtask

    task automatic bus_read(input logic [DMEM_WIDTH-1:0] addr, input logic [7:0] expv);
        req.re    = 1'b1;
        req.we    = 1'b0;
        req.addr  = addr;
        req.wdata = '0;
        next_cycle();
        req = '0;
        check_byte("rdata", rdata, expv);   // Valid the cycle after the strobe
    endtask

    task automatic drive_ext_irq(input logic [2:0] lines, input logic [7:0] expv);
        ext_irq = lines;
        #1;                                 // Encoder is combinational
        check_irq(iflag, ivect, expv[4], expv[1:0]);
        next_cycle();
    endtask

    task automatic expect_uart_byte(input logic [7:0] expv);
        int         waited;
        logic [7:0] got;
        waited = 0;
        while (rx_queue.size() == 0) begin
            if (waited > 12 * (bit_div + 1)) begin
                $display("No UART frame arrived on txd within the expected time");
                abort_run();
            end
            next_cycle();
            waited++;
        end
        got = rx_queue.pop_front();
        check_byte("txd byte", got, expv);
    endtask

    // Line must stay at mark with nothing received
    task automatic expect_quiet(input logic [7:0] cycles);
        repeat (cycles) next_cycle();
        if (rx_queue.size() != 0 || in_frame) begin
            $display("An unexpected UART frame appeared on txd");
            abort_run();
        end
        check_bit("txd", txd, 1'b1);
    endtask

    // Receiver model sampling every bit in its middle
    initial begin : uart_monitor
        in_frame = 1'b0;
        @(posedge arst_n);
        mon_prev = 1'b1;
        forever begin
            next_cycle();
            if (mon_prev && !txd) begin     // Start bit began at the last edge
                in_frame = 1'b1;
                mon_bt   = bit_div + 1;
                repeat (mon_bt / 2) next_cycle();
                check_bit("txd start bit", txd, 1'b0);
                for (int i = 0; i < 8; i++) begin
                    repeat (mon_bt) next_cycle();
                    mon_shift[i] = txd;     // LSB first
                end
                repeat (mon_bt) next_cycle();
                check_bit("txd stop bit", txd, 1'b1);
                rx_queue.push_back(mon_shift);
                in_frame = 1'b0;
            end
            mon_prev = txd;
        end
    end

    initial begin : watchdog
        wait (num_ops > 0);
        #(num_ops * 12 * (DIV_RESET + 1) * 20);
        $display("Timeout: the run did not finish before the watchdog expired");
        abort_run();
    end

    initial begin : main_seq
        int          idx;
        logic [3:0]  op;
        logic [11:0] addr;
        logic [7:0]  wdata;
        logic [7:0]  expv;
        req         = '0;
        sw          = '0;
        ext_irq     = '0;
        num_ops     = 0;
        bit_div     = DIV_RESET;
        void'($urandom(32'h48a5));
        for (idx = 0; idx < MAX_OPS; idx++)
            ops[idx] = '0;                  // Unused entries read as end
        $readmemh("verification/avr_io_testdata.txt", ops);
        while (num_ops < MAX_OPS && ops[num_ops][31:28] != OP_END)
            num_ops++;
        if (num_ops == 0) begin
            $display("The data file holds no operations");
            abort_run();
        end
        @(posedge arst_n);
        next_cycle();
        for (idx = 0; idx < num_ops; idx++) begin
            {op, addr, wdata, expv} = ops[idx];
            idle_gap();
            case (op)
                OP_WRITE: bus_write(addr[DMEM_WIDTH-1:0], wdata);
                OP_READ:  bus_read(addr[DMEM_WIDTH-1:0], expv);
                OP_SW:    sw = wdata;
                OP_IRQ:   drive_ext_irq(wdata[2:0], expv);
                OP_UART:  expect_uart_byte(wdata);
                OP_QUIET: expect_quiet(wdata);
                OP_LED:   check_byte("led", led, wdata);
                default: begin
                    $display("Unknown operation code %h at data file entry %0d", op, idx);
                    abort_run();
                end
            endcase
        end
        $display("All tests passed");
        $finish;
    end

endmodule : tb_avr_io_top

`default_nettype wire

// File: avr_io_top.f
design/avr_io_pkg.sv
design/dbus_decoder.sv
design/data_ram.sv
design/io_regs.sv
design/baud_timer.sv
design/uart_tx_fsm.sv
design/irq_priority_encoder.sv
design/avr_io_top.sv
verification/tb_clock_gen.sv
verification/tb_avr_io_top.sv

// File: verification/avr_io_testdata.txt
// Word is op_addr_wdata_expect in hex, op 1 write, 2 read, 3 sw, 4 ext_irq, 5 UART byte
// op 6 quiet txd for wdata cycles, 8 led value, IRQ expect is iflag at bit 4 and ivect
1_005_a5_00
1_011_3c_00
1_1ff_5a_00
1_000_c3_00
2_005_00_a5
2_011_00_3c
2_1ff_00_5a
2_000_00_c3
1_205_ee_00
1_211_77_00
1_200_81_00
2_005_00_a5
2_011_00_3c
2_000_00_c3
8_000_81_00
2_200_00_81
3_000_6b_00
2_201_00_6b
2_205_00_00
2_207_00_00
4_000_00_00
4_000_01_11
4_000_02_12
4_000_04_13
4_000_06_12
4_000_07_11
4_000_00_00
2_203_00_00
1_203_96_00
5_000_96_00
6_000_10_00
4_000_00_10
2_203_00_02
4_000_05_10
4_000_00_10
1_204_02_00
4_000_00_00
2_203_00_00
1_202_07_00
2_202_00_07
1_203_3c_00
2_203_00_01
1_203_ff_00
5_000_3c_00
6_000_64_00
4_000_06_10
1_204_01_00
4_000_00_10
1_204_02_00
4_000_00_00
0_000_00_00
